// File: rtl/mips_isa_pkg.sv
// Instruction-set definitions for the MIPS32 integer subset run by the core.
// Only the opcodes and function codes the decoder recognises are listed here.
// Anything else decodes as a no-operation.

package mips_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;

    // field positions, lsb of each field
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int SHAMT_LSB  = 6;
    localparam int FUNCT_LSB  = 0;
    localparam int IMM_LSB    = 0;

    // primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type function codes
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

    localparam reg_idx_t REG_ZERO = 5'd0;   // hardwired zero

endpackage

// File: rtl/pipeline_pkg.sv
// Datapath definitions of the five-stage pipeline.
// The pc counts words, not bytes, so the next sequential pc is pc plus one.

package pipeline_pkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W-1:0] pc_t;     // word index into instruction memory

    // ALU operation select
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_t;

    // execute-stage operand source
    typedef enum logic [1:0] {
        FWD_NONE,   // register file value
        FWD_MEM,    // ALU result in M
        FWD_WB      // writeback value in W
    } fwd_sel_t;

    localparam pc_t RESET_PC = '0;

endpackage

// File: rtl/register_file.sv
// 32 x 32 register file with two read ports and a debug read port.
// Reads are combinational and see a write made in the same cycle.
// Register 0 reads zero and ignores writes. Contents are not reset.

module register_file (
    input  logic                   clk,
    input  mips_isa_pkg::reg_idx_t ra1,
    input  mips_isa_pkg::reg_idx_t ra2,
    input  mips_isa_pkg::reg_idx_t ra_dbg,
    output pipeline_pkg::word_t    rd1,
    output pipeline_pkg::word_t    rd2,
    output pipeline_pkg::word_t    rd_dbg,
    input  logic                   we,
    input  mips_isa_pkg::reg_idx_t wa,
    input  pipeline_pkg::word_t    wd
);
    import mips_isa_pkg::*;
    import pipeline_pkg::*;

    word_t regs [32];

    function automatic word_t read_port(reg_idx_t addr);
        if (addr == REG_ZERO)
            return '0;
        if (we && addr == wa)   // write-through
            return wd;
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (we && wa != REG_ZERO)
            regs[wa] <= wd;
    end

    always_comb begin
        rd1    = read_port(ra1);
        rd2    = read_port(ra2);
        rd_dbg = read_port(ra_dbg);
    end

endmodule

// File: rtl/alu.sv
// Integer ALU of the execute stage.
// Shifts take src_b by the instruction's shift amount, as sll does.
// LUI moves the low half of src_b (the immediate) into the upper half.
// There is no zero flag since branches resolve in decode.

module alu (
    input  pipeline_pkg::word_t   src_a,
    input  pipeline_pkg::word_t   src_b,
    input  pipeline_pkg::alu_op_t op,
    input  mips_isa_pkg::shamt_t  shamt,
    output pipeline_pkg::word_t   result
);
    import pipeline_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = src_a + src_b;
            end
            ALU_SUB: begin
                result = src_a - src_b;
            end
            ALU_AND: begin
                result = src_a & src_b;
            end
            ALU_OR: begin
                result = src_a | src_b;
            end
            ALU_SLT: begin
                result = word_t'($signed(src_a) < $signed(src_b));  // signed compare
            end
            ALU_SLL: begin
                result = src_b << shamt;
            end
            ALU_LUI: begin
                result = {src_b[15:0], 16'b0};
            end
            default: begin
                result = src_a + src_b;
            end
        endcase
    end

endmodule

// File: rtl/control_unit.sv
// Decoder of the decode stage.
// Unknown opcodes and unknown R-type function codes give all-zero controls.
// branch_taken uses the comparison operands after M to D forwarding.

module control_unit (
    input  mips_isa_pkg::instr_t  instr,
    input  pipeline_pkg::word_t   cmp_a,
    input  pipeline_pkg::word_t   cmp_b,
    output logic                  reg_write,
    output logic                  reg_dst,
    output logic                  alu_src,
    output logic                  mem_write,
    output logic                  mem_to_reg,
    output logic                  branch,
    output pipeline_pkg::alu_op_t alu_op,
    output logic                  branch_taken
);
    import mips_isa_pkg::*;
    import pipeline_pkg::*;

    opcode_t opcode;
    funct_t  funct;
    logic    is_bne;

    assign opcode = instr[OPCODE_LSB +: $bits(opcode_t)];
    assign funct  = instr[FUNCT_LSB +: $bits(funct_t)];

    always_comb begin
        reg_write  = 1'b0;
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        branch     = 1'b0;
        is_bne     = 1'b0;
        alu_op     = ALU_ADD;

        case (opcode)
            OP_RTYPE: begin
                reg_write = 1'b1;
                reg_dst   = 1'b1;   // rd is the destination
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    default: begin
                        reg_write = 1'b0;
                        reg_dst   = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            OP_LUI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = ALU_LUI;
            end
            OP_LW: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ: branch = 1'b1;
            OP_BNE: begin
                branch = 1'b1;
                is_bne = 1'b1;
            end
            default: ;              // no-operation
        endcase
    end

    // equality flips for bne
    assign branch_taken = branch && ((cmp_a == cmp_b) != is_bne);

endmodule

// File: rtl/hazard_unit.sv
// Forwarding selection and stall/flush generation.
// Execute operands take M before W. Register 0 is never forwarded
// and never causes a stall.
// A taken branch flushes D only when not stalled, since its operands
// may still be stale during the stall cycle.

module hazard_unit (
    input  mips_isa_pkg::reg_idx_t rs_d,
    input  mips_isa_pkg::reg_idx_t rt_d,
    input  mips_isa_pkg::reg_idx_t rs_e,
    input  mips_isa_pkg::reg_idx_t rt_e,
    input  mips_isa_pkg::reg_idx_t wreg_e,
    input  mips_isa_pkg::reg_idx_t wreg_m,
    input  mips_isa_pkg::reg_idx_t wreg_w,
    input  logic                   branch_d,
    input  logic                   branch_taken_d,
    input  logic                   reg_write_e,
    input  logic                   mem_to_reg_e,
    input  logic                   reg_write_m,
    input  logic                   mem_to_reg_m,
    input  logic                   reg_write_w,
    output pipeline_pkg::fwd_sel_t fwd_a_e,
    output pipeline_pkg::fwd_sel_t fwd_b_e,
    output logic                   fwd_a_d,
    output logic                   fwd_b_d,
    output logic                   stall,
    output logic                   flush_d
);
    import mips_isa_pkg::*;
    import pipeline_pkg::*;

    logic d_reads_e;   // D source matches E destination
    logic d_reads_m;   // D source matches M destination
    logic load_use_stall;
    logic branch_stall;

    function automatic fwd_sel_t fwd_select(reg_idx_t src);
        if (src == REG_ZERO)
            return FWD_NONE;
        if (reg_write_m && src == wreg_m)
            return FWD_MEM;
        if (reg_write_w && src == wreg_w)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    always_comb begin
        fwd_a_e = fwd_select(rs_e);
        fwd_b_e = fwd_select(rt_e);
    end

    // branch operands from M
    assign fwd_a_d = rs_d != REG_ZERO && rs_d == wreg_m && reg_write_m;
    assign fwd_b_d = rt_d != REG_ZERO && rt_d == wreg_m && reg_write_m;

    assign d_reads_e = wreg_e != REG_ZERO && (rs_d == wreg_e || rt_d == wreg_e);
    assign d_reads_m = wreg_m != REG_ZERO && (rs_d == wreg_m || rt_d == wreg_m);

    assign load_use_stall = mem_to_reg_e && d_reads_e;
    assign branch_stall   = branch_d && ((reg_write_e && d_reads_e) ||
                                         (mem_to_reg_m && d_reads_m));

    assign stall   = load_use_stall || branch_stall;
    assign flush_d = branch_taken_d && !stall;

endmodule

// File: rtl/pipeline_cpu.sv
// Five-stage pipelined MIPS integer core (F, D, E, M, W).
// Instruction and data memories are combinational reads from outside.
// Data memory is written on the rising edge while dm_we is high.
// Branches resolve in decode with no delay slot. A taken branch costs one
// bubble. reg_addr 0 on the debug port returns the fetch pc.

module pipeline_cpu (
    input  logic                   clk,
    input  logic                   reset,
    input  mips_isa_pkg::reg_idx_t reg_addr,
    output pipeline_pkg::word_t    reg_data,
    output pipeline_pkg::pc_t      im_addr,
    input  mips_isa_pkg::instr_t   im_data,
    output pipeline_pkg::word_t    dm_addr,
    output logic                   dm_we,
    output pipeline_pkg::word_t    dm_wdata,
    input  pipeline_pkg::word_t    dm_rdata
);
    import mips_isa_pkg::*;
    import pipeline_pkg::*;

    // hazard unit outputs
    fwd_sel_t fwd_a_e;
    fwd_sel_t fwd_b_e;
    logic     fwd_a_d;
    logic     fwd_b_d;
    logic     stall;
    logic     flush_d;

    // values fed back from later stages
    word_t    alu_result_m;
    word_t    result_w;
    reg_idx_t wreg_w;
    logic     reg_write_w;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t rf_val, word_t m_val,
                                      word_t w_val);
        case (sel)
            FWD_MEM: return m_val;
            FWD_WB:  return w_val;
            default: return rf_val;
        endcase
    endfunction

    // ************************************************
    // F - fetch
    // ************************************************

    pc_t  pc_f;
    pc_t  pc_plus1_f;
    pc_t  pc_next_f;
    pc_t  pc_branch_d;
    logic branch_taken_d;

    assign pc_plus1_f = pc_f + 1;
    assign pc_next_f  = branch_taken_d ? pc_branch_d : pc_plus1_f;

    always_ff @(posedge clk) begin
        if (reset)
            pc_f <= RESET_PC;
        else if (!stall)
            pc_f <= pc_next_f;
    end

    assign im_addr = pc_f;

    // F/D register, a flush leaves a nop
    instr_t instr_d;
    pc_t    pc_plus1_d;

    always_ff @(posedge clk) begin
        if (reset || flush_d)
            instr_d <= '0;
        else if (!stall)
            instr_d <= im_data;
    end

    always_ff @(posedge clk) begin
        if (!stall)
            pc_plus1_d <= pc_plus1_f;
    end

    // ************************************************
    // D - decode and register read
    // ************************************************

    reg_idx_t rs_d;
    reg_idx_t rt_d;
    reg_idx_t rd_d;
    shamt_t   shamt_d;
    imm_t     imm_d;
    word_t    sign_imm_d;
    word_t    rd1_d;
    word_t    rd2_d;
    word_t    cmp_a_d;
    word_t    cmp_b_d;
    word_t    rf_dbg;

    assign rs_d    = instr_d[RS_LSB +: $bits(reg_idx_t)];
    assign rt_d    = instr_d[RT_LSB +: $bits(reg_idx_t)];
    assign rd_d    = instr_d[RD_LSB +: $bits(reg_idx_t)];
    assign shamt_d = instr_d[SHAMT_LSB +: $bits(shamt_t)];
    assign imm_d   = instr_d[IMM_LSB +: $bits(imm_t)];

    assign sign_imm_d  = {{16{imm_d[15]}}, imm_d};
    assign pc_branch_d = pc_plus1_d + sign_imm_d;   // word offset

    register_file i_register_file (
        .clk    (clk),
        .ra1    (rs_d),
        .ra2    (rt_d),
        .ra_dbg (reg_addr),
        .rd1    (rd1_d),
        .rd2    (rd2_d),
        .rd_dbg (rf_dbg),
        .we     (reg_write_w),
        .wa     (wreg_w),
        .wd     (result_w)
    );

    assign reg_data = (reg_addr != REG_ZERO) ? rf_dbg : pc_f;

    // early compare operands
    assign cmp_a_d = fwd_a_d ? alu_result_m : rd1_d;
    assign cmp_b_d = fwd_b_d ? alu_result_m : rd2_d;

    logic    reg_write_d;
    logic    reg_dst_d;
    logic    alu_src_d;
    logic    mem_write_d;
    logic    mem_to_reg_d;
    logic    branch_d;
    alu_op_t alu_op_d;

    control_unit i_control_unit (
        .instr        (instr_d),
        .cmp_a        (cmp_a_d),
        .cmp_b        (cmp_b_d),
        .reg_write    (reg_write_d),
        .reg_dst      (reg_dst_d),
        .alu_src      (alu_src_d),
        .mem_write    (mem_write_d),
        .mem_to_reg   (mem_to_reg_d),
        .branch       (branch_d),
        .alu_op       (alu_op_d),
        .branch_taken (branch_taken_d)
    );

    // D/E register, stall inserts a bubble
    logic     reg_write_e;
    logic     reg_dst_e;
    logic     alu_src_e;
    logic     mem_write_e;
    logic     mem_to_reg_e;
    alu_op_t  alu_op_e;
    word_t    rd1_e;
    word_t    rd2_e;
    word_t    sign_imm_e;
    reg_idx_t rs_e;
    reg_idx_t rt_e;
    reg_idx_t rd_e;
    shamt_t   shamt_e;

    always_ff @(posedge clk) begin
        if (reset || stall) begin
            reg_write_e  <= 1'b0;
            reg_dst_e    <= 1'b0;
            alu_src_e    <= 1'b0;
            mem_write_e  <= 1'b0;
            mem_to_reg_e <= 1'b0;
            alu_op_e     <= ALU_ADD;
        end else begin
            reg_write_e  <= reg_write_d;
            reg_dst_e    <= reg_dst_d;
            alu_src_e    <= alu_src_d;
            mem_write_e  <= mem_write_d;
            mem_to_reg_e <= mem_to_reg_d;
            alu_op_e     <= alu_op_d;
        end
    end

    always_ff @(posedge clk) begin
        rd1_e      <= rd1_d;
        rd2_e      <= rd2_d;
        sign_imm_e <= sign_imm_d;
        rs_e       <= rs_d;
        rt_e       <= rt_d;
        rd_e       <= rd_d;
        shamt_e    <= shamt_d;
    end

    // ************************************************
    // E - execute
    // ************************************************

    word_t    src_a_e;
    word_t    src_b_e;
    word_t    write_data_e;     // store data after forwarding
    word_t    alu_result_e;
    reg_idx_t wreg_e;

    assign src_a_e      = fwd_mux(fwd_a_e, rd1_e, alu_result_m, result_w);
    assign write_data_e = fwd_mux(fwd_b_e, rd2_e, alu_result_m, result_w);
    assign src_b_e      = alu_src_e ? sign_imm_e : write_data_e;
    assign wreg_e       = reg_dst_e ? rd_e : rt_e;

    alu i_alu (
        .src_a  (src_a_e),
        .src_b  (src_b_e),
        .op     (alu_op_e),
        .shamt  (shamt_e),
        .result (alu_result_e)
    );

    // E/M register
    logic     reg_write_m;
    logic     mem_write_m;
    logic     mem_to_reg_m;
    word_t    write_data_m;
    reg_idx_t wreg_m;

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_m  <= 1'b0;
            mem_write_m  <= 1'b0;
            mem_to_reg_m <= 1'b0;
        end else begin
            reg_write_m  <= reg_write_e;
            mem_write_m  <= mem_write_e;
            mem_to_reg_m <= mem_to_reg_e;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_m <= alu_result_e;
        write_data_m <= write_data_e;
        wreg_m       <= wreg_e;
    end

    // ************************************************
    // M - memory
    // ************************************************

    assign dm_addr  = alu_result_m;
    assign dm_we    = mem_write_m;
    assign dm_wdata = write_data_m;

    // M/W register
    logic  mem_to_reg_w;
    word_t alu_result_w;
    word_t read_data_w;

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_w  <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end else begin
            reg_write_w  <= reg_write_m;
            mem_to_reg_w <= mem_to_reg_m;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_w <= alu_result_m;
        read_data_w  <= dm_rdata;
        wreg_w       <= wreg_m;
    end

    // ************************************************
    // W - writeback
    // ************************************************

    assign result_w = mem_to_reg_w ? read_data_w : alu_result_w;

    hazard_unit i_hazard_unit (
        .rs_d           (rs_d),
        .rt_d           (rt_d),
        .rs_e           (rs_e),
        .rt_e           (rt_e),
        .wreg_e         (wreg_e),
        .wreg_m         (wreg_m),
        .wreg_w         (wreg_w),
        .branch_d       (branch_d),
        .branch_taken_d (branch_taken_d),
        .reg_write_e    (reg_write_e),
        .mem_to_reg_e   (mem_to_reg_e),
        .reg_write_m    (reg_write_m),
        .mem_to_reg_m   (mem_to_reg_m),
        .reg_write_w    (reg_write_w),
        .fwd_a_e        (fwd_a_e),
        .fwd_b_e        (fwd_b_e),
        .fwd_a_d        (fwd_a_d),
        .fwd_b_d        (fwd_b_d),
        .stall          (stall),
        .flush_d        (flush_d)
    );

endmodule

// File: test/tb_cpu_tasks.svh
// Encoders, program runner and directed tests of the core testbench.
// Included inside tb_pipeline_cpu; uses its signals and memories directly.

`ifndef TB_CPU_TASKS_SVH
`define TB_CPU_TASKS_SVH

// **************************************************
// instruction encoders and helpers
// **************************************************

function automatic instr_t enc_r(funct_t fn, int rs, int rt, int rd, int sh);
    return {OP_RTYPE, reg_idx_t'(rs), reg_idx_t'(rt), reg_idx_t'(rd), shamt_t'(sh), fn};
endfunction

function automatic instr_t enc_i(opcode_t op, int rs, int rt, int imm);
    return {op, reg_idx_t'(rs), reg_idx_t'(rt), imm_t'(imm)};
endfunction

function automatic word_t sext(imm_t imm);
    return {{16{imm[15]}}, imm};
endfunction

// galois lfsr, one step per returned bit
function automatic word_t rand_bits(int n);
    word_t r;
    logic  b;
    r = '0;
    for (int i = 0; i < n; i++) begin
        b          = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        r          = {r[30:0], b};
    end
    return r;
endfunction

// **************************************************
// program runner and checks
// **************************************************

task automatic run_program();
    int cycles;
    halt_pc = pc_t'(prog.size());
    prog.push_back(enc_i(OP_BEQ, 0, 0, -1));    // self-loop
    reset = 1'b1;
    reg_addr = REG_ZERO;
    for (int i = 0; i < IMEM_WORDS; i++)
        imem[i] = (i < prog.size()) ? prog[i] : '0;
    for (int a = 0; a < DMEM_WORDS; a++)
        dmem[a] = 32'hd0d0_0000 | word_t'(a);
    store_addr_q.delete();
    store_data_q.delete();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
    // no store can reach M within the first three cycles
    for (int c = 0; c < 3; c++) begin
        if (dm_we !== 1'b0) begin
            $display("dm_we was not low in cycle %0d after reset", c);
            errors++;
        end
        @(posedge clk);
        #1;
    end
    cycles = 0;
    while (reg_data !== halt_pc && cycles < HALT_TIMEOUT) begin
        @(posedge clk);
        #1;
        cycles++;
    end
    if (cycles >= HALT_TIMEOUT) begin
        $display("program did not reach its halt loop at %0d in time", halt_pc);
        errors++;
    end
    repeat (DRAIN_CYCLES) @(posedge clk);
    prog.delete();
endtask

task automatic check_reg(string name, int idx, word_t exp);
    word_t got;
    @(posedge clk);
    #1 reg_addr = reg_idx_t'(idx);
    #1 got = reg_data;
    if (got !== exp) begin
        $display("[FAIL] %s: r%0d expected %08h actual %08h", name, idx, exp, got);
        errors++;
    end
endtask

task automatic finish_test(string name, int err_before);
    tests_run++;
    if (errors != err_before) begin
        tests_failed++;
        $display("test %s: failed", name);
    end else begin
        $display("test %s: passed", name);
    end
endtask

// **************************************************
// directed tests
// **************************************************

task automatic test_dependency_chain();
    int    e0;
    imm_t  i1;
    imm_t  i2;
    imm_t  i3;
    word_t e [11];
    e0 = errors;
    i1 = imm_t'(rand_bits(16));
    i2 = imm_t'(rand_bits(16));
    i3 = imm_t'(rand_bits(16));
    prog.push_back(enc_i(OP_ADDIU, 0, 1, int'(i1)));
    prog.push_back(enc_i(OP_ADDIU, 1, 2, int'(i2)));
    prog.push_back(enc_r(FN_ADDU, 2, 1, 3, 0));
    prog.push_back(enc_r(FN_SUBU, 3, 1, 4, 0));
    prog.push_back(enc_r(FN_AND, 4, 3, 5, 0));
    prog.push_back(enc_r(FN_OR, 5, 1, 6, 0));
    prog.push_back(enc_r(FN_SLT, 6, 2, 7, 0));
    prog.push_back(enc_r(FN_SLL, 0, 6, 8, 3));
    prog.push_back(enc_i(OP_LUI, 0, 9, int'(i3)));
    prog.push_back(enc_r(FN_ADDU, 9, 8, 10, 0));
    run_program();
    e[1]  = sext(i1);
    e[2]  = e[1] + sext(i2);
    e[3]  = e[2] + e[1];
    e[4]  = e[3] - e[1];
    e[5]  = e[4] & e[3];
    e[6]  = e[5] | e[1];
    e[7]  = ($signed(e[6]) < $signed(e[2])) ? 32'd1 : 32'd0;
    e[8]  = e[6] << 3;
    e[9]  = {i3, 16'h0000};
    e[10] = e[9] + e[8];
    for (int r = 1; r <= 10; r++)
        check_reg("dependency_chain", r, e[r]);
    finish_test("dependency_chain", e0);
endtask

task automatic test_load_use();
    int e0;
    e0 = errors;
    prog.push_back(enc_i(OP_LUI, 0, 2, 'h1234));
    prog.push_back(enc_i(OP_ADDIU, 2, 3, 'h0567));
    prog.push_back(enc_i(OP_SW, 0, 3, 5));
    prog.push_back(enc_i(OP_LW, 0, 4, 5));
    prog.push_back(enc_i(OP_ADDIU, 4, 5, 9));   // uses the load at once
    run_program();
    check_reg("load_use", 5, 32'h1234_0570);
    if (dmem[5] !== 32'h1234_0567) begin
        $display("[FAIL] load_use: dmem[5] expected %08h actual %08h",
                 32'h1234_0567, dmem[5]);
        errors++;
    end
    finish_test("load_use", e0);
endtask

task automatic test_branches();
    int e0;
    e0 = errors;
    prog.push_back(enc_i(OP_ADDIU, 0, 1, 5));
    prog.push_back(enc_i(OP_ADDIU, 0, 2, 5));
    prog.push_back(enc_i(OP_ADDIU, 0, 3, 6));
    prog.push_back(enc_i(OP_ADDIU, 0, 10, 'h77));
    prog.push_back(enc_i(OP_ADDIU, 0, 12, 'h77));
    prog.push_back(enc_i(OP_ADDIU, 0, 14, 0));
    prog.push_back(enc_i(OP_ADDIU, 0, 15, 0));
    prog.push_back(enc_i(OP_BEQ, 1, 2, 1));     // taken
    prog.push_back(enc_i(OP_ADDIU, 0, 10, 1));
    prog.push_back(enc_i(OP_ADDIU, 0, 11, 2));
    prog.push_back(enc_i(OP_BNE, 1, 3, 1));     // taken
    prog.push_back(enc_i(OP_ADDIU, 0, 12, 3));
    prog.push_back(enc_i(OP_ADDIU, 0, 13, 4));
    prog.push_back(enc_i(OP_BEQ, 1, 3, 1));     // not taken
    prog.push_back(enc_i(OP_ADDIU, 0, 14, 5));
    prog.push_back(enc_i(OP_BNE, 1, 2, 1));     // not taken
    prog.push_back(enc_i(OP_ADDIU, 0, 15, 6));
    run_program();
    check_reg("branches", 10, 32'h77);
    check_reg("branches", 11, 32'd2);
    check_reg("branches", 12, 32'h77);
    check_reg("branches", 13, 32'd4);
    check_reg("branches", 14, 32'd5);
    check_reg("branches", 15, 32'd6);
    finish_test("branches", e0);
endtask

task automatic test_branch_on_fresh_operand();
    int e0;
    e0 = errors;
    prog.push_back(enc_i(OP_ADDIU, 0, 20, 'h77));
    prog.push_back(enc_i(OP_ADDIU, 0, 22, 'h77));
    prog.push_back(enc_i(OP_ADDIU, 0, 24, 'h77));
    prog.push_back(enc_i(OP_ADDIU, 0, 2, 9));
    prog.push_back(enc_i(OP_ADDIU, 0, 1, 9));
    prog.push_back(enc_i(OP_BEQ, 1, 2, 1));     // alu producer right before
    prog.push_back(enc_i(OP_ADDIU, 0, 20, 1));
    prog.push_back(enc_i(OP_ADDIU, 0, 21, 2));
    prog.push_back(enc_i(OP_SW, 0, 1, 3));
    prog.push_back(enc_i(OP_LW, 0, 4, 3));
    prog.push_back(enc_i(OP_BNE, 4, 2, 1));     // load producer, not taken
    prog.push_back(enc_i(OP_ADDIU, 0, 22, 3));
    prog.push_back(enc_i(OP_ADDIU, 0, 23, 4));
    prog.push_back(enc_i(OP_LW, 0, 5, 3));
    prog.push_back(enc_i(OP_BNE, 5, 0, 1));     // load producer, taken
    prog.push_back(enc_i(OP_ADDIU, 0, 24, 5));
    prog.push_back(enc_i(OP_ADDIU, 0, 25, 6));
    run_program();
    check_reg("branch_fresh_operand", 20, 32'h77);
    check_reg("branch_fresh_operand", 21, 32'd2);
    check_reg("branch_fresh_operand", 22, 32'd3);
    check_reg("branch_fresh_operand", 23, 32'd4);
    check_reg("branch_fresh_operand", 24, 32'h77);
    check_reg("branch_fresh_operand", 25, 32'd6);
    finish_test("branch_fresh_operand", e0);
endtask

task automatic test_stores_and_zero_reg();
    int    e0;
    word_t exp_addr [3];
    word_t exp_data [3];
    e0 = errors;
    exp_addr = '{32'd10, 32'd11, 32'h2e};
    exp_data = '{32'h11, 32'h22, 32'h11};
    prog.push_back(enc_i(OP_ADDIU, 0, 1, 'h11));
    prog.push_back(enc_i(OP_SW, 0, 1, 10));
    prog.push_back(enc_i(OP_ADDIU, 0, 2, 'h22));
    prog.push_back(enc_i(OP_SW, 0, 2, 11));
    prog.push_back(enc_i(OP_SW, 2, 1, 12));
    prog.push_back(enc_i(OP_ADDIU, 0, 0, 'h55));    // write to r0
    prog.push_back(enc_r(FN_ADDU, 0, 1, 3, 0));
    run_program();
    if (store_addr_q.size() != 3) begin
        $display("[FAIL] store_sequence: store count expected %0d actual %0d",
                 3, store_addr_q.size());
        errors++;
    end else begin
        for (int i = 0; i < 3; i++) begin
            if (store_addr_q[i] !== exp_addr[i] || store_data_q[i] !== exp_data[i]) begin
                $display("[FAIL] store_sequence: store %0d expected %08h/%08h actual %08h/%08h",
                         i, exp_addr[i], exp_data[i], store_addr_q[i], store_data_q[i]);
                errors++;
            end
        end
    end
    // debug address 0 shows the pc, so r0 is checked through a copy
    check_reg("store_sequence", 3, 32'h11);
    finish_test("store_sequence", e0);
endtask

`endif

// File: test/tb_pipeline_cpu.sv
// Testbench for the five-stage core.
// Instruction memory holds 64 words, data memory 256 words indexed by the
// low 8 bits of dm_addr (word addresses, no byte lanes).
// Every program ends in a beq self-loop that the tests poll for.

module tb_pipeline_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    import mips_isa_pkg::*;
    import pipeline_pkg::*;

    localparam int IMEM_WORDS  = 64;
    localparam int DMEM_WORDS  = 256;
    localparam int RESET_CYCLES = 16;
    localparam int HALT_TIMEOUT = 500;
    localparam int DRAIN_CYCLES = 8;    // lets the last writes leave the pipe

    logic     clk;
    logic     reset;
    reg_idx_t reg_addr;
    word_t    reg_data;
    pc_t      im_addr;
    instr_t   im_data;
    word_t    dm_addr;
    logic     dm_we;
    word_t    dm_wdata;
    word_t    dm_rdata;

    instr_t imem [IMEM_WORDS];
    word_t  dmem [DMEM_WORDS];

    // test bookkeeping
    int     errors;
    int     tests_run;
    int     tests_failed;
    word_t  lfsr_state;
    instr_t prog [$];
    pc_t    halt_pc;
    word_t  store_addr_q [$];
    word_t  store_data_q [$];

    pipeline_cpu uut (
        .clk      (clk),
        .reset    (reset),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .im_addr  (im_addr),
        .im_data  (im_data),
        .dm_addr  (dm_addr),
        .dm_we    (dm_we),
        .dm_wdata (dm_wdata),
        .dm_rdata (dm_rdata)
    );

    // **************************************************
    // clock and memory models
    // **************************************************

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign im_data  = imem[im_addr[5:0]];
    assign dm_rdata = dmem[dm_addr[7:0]];

    always @(posedge clk) begin
        if (!reset && dm_we) begin
            dmem[dm_addr[7:0]] <= dm_wdata;
            store_addr_q.push_back(dm_addr);    // store log for test 5
            store_data_q.push_back(dm_wdata);
        end
    end

    `include "tb_cpu_tasks.svh"

    // **************************************************
    // test sequence
    // **************************************************

    initial begin
        reset        = 1'b1;
        reg_addr     = REG_ZERO;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lfsr_state   = 32'd88097;

        test_dependency_chain();
        test_load_use();
        test_branches();
        test_branch_on_fresh_operand();
        test_stores_and_zero_reg();

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // global watchdog on top of the per-wait timeouts
    initial begin
        #2ms;
        $display("simulation ran past its time limit");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: pipeline_cpu.f
+incdir+test
rtl/mips_isa_pkg.sv
rtl/pipeline_pkg.sv
rtl/register_file.sv
rtl/alu.sv
rtl/control_unit.sv
rtl/hazard_unit.sv
rtl/pipeline_cpu.sv
test/tb_pipeline_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the pipeline_cpu testbench with Verilator and runs it.
# Exit status is nonzero unless the log holds the pass line.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
    --top-module tb_pipeline_cpu \
    -f pipeline_cpu.f \
    -o sim_pipeline_cpu

./obj_dir/sim_pipeline_cpu | tee "$LOG"

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
exit 1
